// ==== source/ts3d_pkg.sv ====
package ts3d_pkg;

    // ====================
    // widths
    // ====================
    localparam int PORT_WIDTH = 32;
    localparam int ACT_WIDTH  = 8;
    localparam int WEI_WIDTH  = 8;
    // 8 taps of 8x8 products fit with margin
    localparam int PSUM_WIDTH = 20;
    localparam int MAX_TAPS   = 8;
    localparam int TAP_WIDTH  = 3;

    typedef logic        [PORT_WIDTH-1:0] port_word_t;
    typedef logic signed [ACT_WIDTH-1:0]  act_t;
    typedef logic signed [WEI_WIDTH-1:0]  wei_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;
    typedef logic        [TAP_WIDTH-1:0]  tap_idx_t;
    typedef logic        [3:0]            win_cnt_t;

    // ====================
    // config word fields
    // ====================
    localparam int CFG_TAPS_LSB = 0;
    localparam int CFG_TAPS_MSB = 2;
    localparam int CFG_WIN_LSB  = 4;
    localparam int CFG_WIN_MSB  = 7;
    localparam int CFG_POOL_LSB = 8;
    localparam int CFG_POOL_MSB = 9;

    typedef enum logic [1:0] {
        PH_CFG,
        PH_WEI,
        PH_ACT
    } layer_phase_t;

endpackage

// ==== source/ts3d_ifs.sv ====
`timescale 1ns/1ps

// activation beats from the sequencer, tagged with their tap
interface act_if import ts3d_pkg::*; ();
    logic     valid;
    logic     ready;
    act_t     act;
    tap_idx_t tap;
    logic     win_last;
    logic     group_last;

    modport src (
        output valid, act, tap, win_last, group_last,
        input  ready
    );

    modport snk (
        input  valid, act, tap, win_last, group_last,
        output ready
    );
endinterface

// activation paired with a full weight row, one weight per lane
interface mac_if import ts3d_pkg::*; #(
    parameter int NUM_PE = 4
) ();
    logic                    valid;
    logic                    ready;
    act_t                    act;
    wei_t [NUM_PE-1:0]       wei_row;
    logic                    win_last;
    logic                    group_last;

    modport src (
        output valid, act, wei_row, win_last, group_last,
        input  ready
    );

    modport snk (
        input  valid, act, wei_row, win_last, group_last,
        output ready
    );
endinterface

// ==== source/layer_cfg.sv ====
`timescale 1ns/1ps

module layer_cfg import ts3d_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rd_val,
    input  port_word_t rd_data,
    output logic       rd_rdy,
    output logic       wei_we,
    output tap_idx_t   wei_tap,
    output port_word_t wei_word,
    act_if.src         act_src
);

    layer_phase_t phase;
    tap_idx_t     taps_m1;
    win_cnt_t     win_m1;
    logic [1:0]   pool_shift;
    tap_idx_t     tap_cnt;
    win_cnt_t     win_cnt;
    logic [1:0]   grp_cnt;
    logic [2:0]   grp_size;
    logic         rd_fire;
    logic         win_last;
    logic         grp_close;

    // ====================
    // stream steering
    // ====================
    // cfg and weight words are always taken, activations wait on the buffer
    assign rd_rdy  = (phase != PH_ACT) || act_src.ready;
    assign rd_fire = rd_val && rd_rdy;

    assign wei_we   = (phase == PH_WEI) && rd_val;
    assign wei_tap  = tap_cnt;
    assign wei_word = rd_data;

    assign grp_size  = 3'd1 << pool_shift;
    assign win_last  = (tap_cnt == taps_m1);
    // last window of the layer closes a short group too
    assign grp_close = ({1'b0, grp_cnt} == grp_size - 3'd1) || (win_cnt == win_m1);

    assign act_src.valid      = (phase == PH_ACT) && rd_val;
    assign act_src.act        = rd_data[ACT_WIDTH-1:0];
    assign act_src.tap        = tap_cnt;
    assign act_src.win_last   = win_last;
    assign act_src.group_last = win_last && grp_close;

    // ====================
    // phase sequencing
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= PH_CFG;
            taps_m1    <= '0;
            win_m1     <= '0;
            pool_shift <= '0;
            tap_cnt    <= '0;
            win_cnt    <= '0;
            grp_cnt    <= '0;
        end else if (rd_fire) begin
            case (phase)
                PH_CFG: begin
                    taps_m1    <= rd_data[CFG_TAPS_MSB:CFG_TAPS_LSB];
                    win_m1     <= rd_data[CFG_WIN_MSB:CFG_WIN_LSB];
                    pool_shift <= rd_data[CFG_POOL_MSB:CFG_POOL_LSB];
                    tap_cnt    <= '0;
                    win_cnt    <= '0;
                    grp_cnt    <= '0;
                    phase      <= PH_WEI;
                end
                PH_WEI: begin
                    if (win_last) begin
                        tap_cnt <= '0;
                        phase   <= PH_ACT;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                default: begin
                    if (!win_last) begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end else begin
                        tap_cnt <= '0;
                        win_cnt <= win_cnt + 1'b1;
                        grp_cnt <= grp_close ? 2'd0 : grp_cnt + 1'b1;
                        // layer done, next word is a config word
                        if (win_cnt == win_m1) begin
                            phase <= PH_CFG;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== source/global_buffer.sv ====
`timescale 1ns/1ps

module global_buffer import ts3d_pkg::*; #(
    parameter int NUM_PE = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wei_we,
    input  tap_idx_t   wei_tap,
    input  port_word_t wei_word,
    act_if.snk         act_snk,
    mac_if.src         mac_src
);

    // one row per tap, lane j weight in byte j of the word
    wei_t [NUM_PE-1:0] wei_mem [MAX_TAPS];

    logic stage_vld;
    logic act_fire;

    always_ff @(posedge clk) begin
        if (wei_we) begin
            for (int j = 0; j < NUM_PE; j++) begin
                wei_mem[wei_tap][j] <= wei_word[j*WEI_WIDTH +: WEI_WIDTH];
            end
        end
    end

    // ====================
    // pairing stage
    // ====================
    assign act_snk.ready = !stage_vld || mac_src.ready;
    assign act_fire      = act_snk.valid && act_snk.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_vld <= 1'b0;
        end else if (act_snk.ready) begin
            stage_vld <= act_snk.valid;
        end
    end

    // row is captured here so later weight writes cannot disturb it
    always_ff @(posedge clk) begin
        if (act_fire) begin
            mac_src.act        <= act_snk.act;
            mac_src.wei_row    <= wei_mem[act_snk.tap];
            mac_src.win_last   <= act_snk.win_last;
            mac_src.group_last <= act_snk.group_last;
        end
    end

    assign mac_src.valid = stage_vld;

endmodule

// ==== source/pe_array.sv ====
`timescale 1ns/1ps

module pe_array import ts3d_pkg::*; #(
    parameter int NUM_PE = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    mac_if.snk                mac_snk,
    output logic              psum_valid,
    input  logic              psum_ready,
    output psum_t [NUM_PE-1:0] psum_vec,
    output logic              psum_group_last
);

    psum_t [NUM_PE-1:0] acc;
    psum_t [NUM_PE-1:0] next_sum;
    logic               restart;
    logic               mac_fire;

    // only a window end needs the output slot free
    assign mac_snk.ready = !(mac_snk.win_last && psum_valid && !psum_ready);
    assign mac_fire      = mac_snk.valid && mac_snk.ready;

    always_comb begin
        for (int j = 0; j < NUM_PE; j++) begin
            next_sum[j] = (restart ? psum_t'(0) : acc[j]) + mac_snk.act * mac_snk.wei_row[j];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            restart    <= 1'b1;
            psum_valid <= 1'b0;
        end else begin
            if (mac_fire) begin
                restart <= mac_snk.win_last;
            end
            if (mac_fire && mac_snk.win_last) begin
                psum_valid <= 1'b1;
            end else if (psum_ready) begin
                psum_valid <= 1'b0;
            end
        end
    end

    // ====================
    // accumulators
    // ====================
    always_ff @(posedge clk) begin
        if (mac_fire) begin
            acc <= next_sum;
            if (mac_snk.win_last) begin
                psum_vec        <= next_sum;
                psum_group_last <= mac_snk.group_last;
            end
        end
    end

endmodule

// ==== source/max_pool.sv ====
`timescale 1ns/1ps

module max_pool import ts3d_pkg::*; #(
    parameter int NUM_PE = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psum_valid,
    output logic               psum_ready,
    input  psum_t [NUM_PE-1:0] psum_vec,
    input  logic               psum_group_last,
    output logic               pool_valid,
    input  logic               pool_ready,
    output psum_t [NUM_PE-1:0] pool_vec
);

    psum_t [NUM_PE-1:0] run_max;
    psum_t [NUM_PE-1:0] next_max;
    logic               first;
    logic               psum_fire;

    assign psum_ready = !pool_valid || pool_ready;
    assign psum_fire  = psum_valid && psum_ready;

    // signed compare, first window of a group just loads
    always_comb begin
        for (int j = 0; j < NUM_PE; j++) begin
            if (first || psum_vec[j] > run_max[j]) begin
                next_max[j] = psum_vec[j];
            end else begin
                next_max[j] = run_max[j];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first      <= 1'b1;
            pool_valid <= 1'b0;
        end else begin
            if (psum_fire) begin
                first <= psum_group_last;
            end
            if (psum_fire && psum_group_last) begin
                pool_valid <= 1'b1;
            end else if (pool_ready) begin
                pool_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (psum_fire) begin
            run_max <= next_max;
            if (psum_group_last) begin
                pool_vec <= next_max;
            end
        end
    end

endmodule

// ==== source/pool_out.sv ====
`timescale 1ns/1ps

module pool_out import ts3d_pkg::*; #(
    parameter int NUM_PE = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pool_valid,
    output logic               pool_ready,
    input  psum_t [NUM_PE-1:0] pool_vec,
    output logic               wr_val,
    input  logic               wr_rdy,
    output port_word_t         wr_data
);

    localparam int LW = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;

    psum_t [NUM_PE-1:0] shreg;
    logic [LW-1:0]      lane_cnt;
    logic               busy;
    logic               last_lane;
    logic               wr_fire;

    assign wr_val    = busy;
    assign wr_fire   = wr_val && wr_rdy;
    assign last_lane = (lane_cnt == LW'(NUM_PE - 1));
    // a new vector may load on the handshake of the last lane
    assign pool_ready = !busy || (wr_fire && last_lane);

    // lane 0 always sits at the bottom of the shift register
    assign wr_data = {{(PORT_WIDTH - PSUM_WIDTH){shreg[0][PSUM_WIDTH-1]}}, shreg[0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            lane_cnt <= '0;
        end else if (pool_valid && pool_ready) begin
            busy     <= 1'b1;
            lane_cnt <= '0;
        end else if (wr_fire) begin
            busy     <= !last_lane;
            lane_cnt <= lane_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pool_valid && pool_ready) begin
            shreg <= pool_vec;
        end else if (wr_fire) begin
            for (int j = 0; j < NUM_PE - 1; j++) begin
                shreg[j] <= shreg[j+1];
            end
        end
    end

endmodule

// ==== source/ts3d_top.sv ====
`timescale 1ns/1ps

module ts3d_top import ts3d_pkg::*; #(
    parameter int NUM_PE = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rd_val,
    output logic       rd_rdy,
    input  port_word_t rd_data,
    output logic       wr_val,
    input  logic       wr_rdy,
    output port_word_t wr_data
);

    // ====================
    // internal channels
    // ====================
    logic               wei_we;
    tap_idx_t           wei_tap;
    port_word_t         wei_word;
    logic               psum_valid;
    logic               psum_ready;
    psum_t [NUM_PE-1:0] psum_vec;
    logic               psum_group_last;
    logic               pool_valid;
    logic               pool_ready;
    psum_t [NUM_PE-1:0] pool_vec;

    act_if                   act_ch ();
    mac_if #(.NUM_PE(NUM_PE)) mac_ch ();

    // ====================
    // pipeline
    // ====================
    layer_cfg cfg_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_val   (rd_val),
        .rd_data  (rd_data),
        .rd_rdy   (rd_rdy),
        .wei_we   (wei_we),
        .wei_tap  (wei_tap),
        .wei_word (wei_word),
        .act_src  (act_ch.src)
    );

    global_buffer #(.NUM_PE(NUM_PE)) gb_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wei_we   (wei_we),
        .wei_tap  (wei_tap),
        .wei_word (wei_word),
        .act_snk  (act_ch.snk),
        .mac_src  (mac_ch.src)
    );

    pe_array #(.NUM_PE(NUM_PE)) pe_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .mac_snk         (mac_ch.snk),
        .psum_valid      (psum_valid),
        .psum_ready      (psum_ready),
        .psum_vec        (psum_vec),
        .psum_group_last (psum_group_last)
    );

    max_pool #(.NUM_PE(NUM_PE)) pool_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .psum_valid      (psum_valid),
        .psum_ready      (psum_ready),
        .psum_vec        (psum_vec),
        .psum_group_last (psum_group_last),
        .pool_valid      (pool_valid),
        .pool_ready      (pool_ready),
        .pool_vec        (pool_vec)
    );

    pool_out #(.NUM_PE(NUM_PE)) out_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pool_valid (pool_valid),
        .pool_ready (pool_ready),
        .pool_vec   (pool_vec),
        .wr_val     (wr_val),
        .wr_rdy     (wr_rdy),
        .wr_data    (wr_data)
    );

endmodule

// ==== verification/ts3d_sva.sv ====
`timescale 1ns/1ps

module ts3d_sva import ts3d_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       rd_rdy,
    input logic       wr_val,
    input logic       wr_rdy,
    input port_word_t wr_data
);

    // ====================
    // write stream hold
    // ====================
    property wr_val_hold_p;
        @(posedge clk) disable iff (!rst_n)
            (wr_val && !wr_rdy) |=> wr_val;
    endproperty

    property wr_data_hold_p;
        @(posedge clk) disable iff (!rst_n)
            (wr_val && !wr_rdy) |=> $stable(wr_data);
    endproperty

    // first edge out of reset
    property reset_exit_p;
        @(posedge clk) $rose(rst_n) |-> (rd_rdy && !wr_val);
    endproperty

    wr_val_hold_a: assert property (wr_val_hold_p)
        else $error("wr_val dropped before wr_rdy took the word");

    wr_data_hold_a: assert property (wr_data_hold_p)
        else $error("wr_data changed while the word was waiting for wr_rdy");

    reset_exit_a: assert property (reset_exit_p)
        else $error("rd_rdy low or wr_val high in the first cycle after reset");

endmodule

bind ts3d_top ts3d_sva sva_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_rdy  (rd_rdy),
    .wr_val  (wr_val),
    .wr_rdy  (wr_rdy),
    .wr_data (wr_data)
);

// ==== verification/ts3d_tb.sv ====
`timescale 1ns/1ps

module ts3d_tb import ts3d_pkg::*; ();

    localparam int NUM_PE      = 4;
    localparam int CLK_PERIOD  = 40;
    localparam int WAIT_LIMIT  = 1000;
    localparam int DRAIN_LIMIT = 4000;
    localparam int NUM_ROWS    = 9;

    typedef struct packed {
        int taps;
        int wins;
        int pool_shift;
        int back_pressure;
        int extreme;
        int exp_words;
    } layer_row_t;

    // ====================
    // layer table
    // ====================
    // taps, windows, pool shift, back-pressure, extreme values, output words
    localparam layer_row_t ROWS [NUM_ROWS] = '{
        '{1,  1, 0, 0, 0,  4},
        '{8,  3, 0, 0, 1, 12},
        '{3,  8, 1, 0, 0, 16},
        '{2,  8, 2, 0, 0,  8},
        // short tail groups of 3 and 1 windows
        '{4,  7, 2, 0, 0,  8},
        '{2,  5, 1, 0, 0, 12},
        '{1, 16, 0, 1, 0, 64},
        '{5, 16, 2, 1, 0, 16},
        '{8, 16, 1, 0, 1, 32}
    };

    logic       clk;
    logic       rst_n;
    logic       rd_val;
    logic       rd_rdy;
    port_word_t rd_data;
    logic       wr_val;
    logic       wr_rdy;
    port_word_t wr_data;

    integer     seed;
    port_word_t stim_q [$];
    bit         stim_bp_q [$];
    port_word_t exp_q [$];
    int         errors;
    int         timeouts;
    int         received;
    int         total_exp;
    bit         bp_en;
    bit         rd_rdy_low_seen;
    bit         aborted;

    ts3d_top #(.NUM_PE(NUM_PE)) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_val  (rd_val),
        .rd_rdy  (rd_rdy),
        .rd_data (rd_data),
        .wr_val  (wr_val),
        .wr_rdy  (wr_rdy),
        .wr_data (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // signed byte of a stream word
    function automatic int byte_val(input port_word_t w, input int idx);
        logic signed [7:0] b;
        b = w[idx*8 +: 8];
        return int'(b);
    endfunction

    // every byte either -128 or 127
    function automatic port_word_t extreme_word();
        port_word_t w;
        for (int j = 0; j < 4; j++) begin
            w[j*8 +: 8] = ($random(seed) % 2 == 0) ? 8'h80 : 8'h7f;
        end
        return w;
    endfunction

    // ====================
    // reference model
    // ====================
    task automatic build_layer(input int r);
        int         wgt [MAX_TAPS][NUM_PE];
        int         psum [NUM_PE];
        int         pmax [NUM_PE];
        int         in_grp;
        int         av;
        bit         bp;
        port_word_t w;
        bp     = (ROWS[r].back_pressure != 0);
        in_grp = 0;
        w = port_word_t'((ROWS[r].taps - 1) | ((ROWS[r].wins - 1) << 4)
                         | (ROWS[r].pool_shift << 8));
        stim_q.push_back(w);
        stim_bp_q.push_back(bp);
        for (int k = 0; k < ROWS[r].taps; k++) begin
            w = (ROWS[r].extreme != 0) ? extreme_word() : $random(seed);
            stim_q.push_back(w);
            stim_bp_q.push_back(bp);
            for (int j = 0; j < NUM_PE; j++) begin
                wgt[k][j] = byte_val(w, j);
            end
        end
        for (int n = 0; n < ROWS[r].wins; n++) begin
            for (int j = 0; j < NUM_PE; j++) begin
                psum[j] = 0;
            end
            for (int k = 0; k < ROWS[r].taps; k++) begin
                w = (ROWS[r].extreme != 0) ? extreme_word() : $random(seed);
                stim_q.push_back(w);
                stim_bp_q.push_back(bp);
                av = byte_val(w, 0);
                for (int j = 0; j < NUM_PE; j++) begin
                    psum[j] += wgt[k][j] * av;
                end
            end
            for (int j = 0; j < NUM_PE; j++) begin
                pmax[j] = (in_grp == 0 || psum[j] > pmax[j]) ? psum[j] : pmax[j];
            end
            in_grp++;
            // last window of the layer closes its group early
            if (in_grp == (1 << ROWS[r].pool_shift) || n == ROWS[r].wins - 1) begin
                for (int j = 0; j < NUM_PE; j++) begin
                    exp_q.push_back(port_word_t'(pmax[j]));
                end
                in_grp = 0;
            end
        end
    endtask

    // one word on the read stream, called on a falling edge
    task automatic send_word(input port_word_t word, input bit bp);
        int waited;
        waited  = 0;
        rd_val  = 1'b1;
        rd_data = word;
        #(CLK_PERIOD / 4);
        bp_en = bp;
        while (!rd_rdy && waited < WAIT_LIMIT) begin
            rd_rdy_low_seen = 1'b1;
            @(negedge clk);
            #(CLK_PERIOD / 4);
            waited++;
        end
        if (!rd_rdy) begin
            $display("timeout: rd_rdy stayed low for %0d cycles at %0t", waited, $time);
            timeouts++;
            aborted = 1'b1;
        end
        @(negedge clk);
    endtask

    // drives wr_rdy and checks each word that will be taken at the next edge
    task automatic watch_output();
        port_word_t expected;
        forever begin
            @(negedge clk);
            wr_rdy = !bp_en || ($random(seed) % 2 == 0);
            if (wr_val && wr_rdy) begin
                assert (exp_q.size() > 0) else begin
                    $display("unexpected extra output word %08h at %0t", wr_data, $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    expected = exp_q.pop_front();
                    assert (wr_data == expected) else begin
                        $display("FAILED at %0t: word %0d expected %08h got %08h",
                                 $time, received, expected, wr_data);
                        errors++;
                    end
                end
                received++;
            end
        end
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int waited;
        seed            = 67336;
        rst_n           = 1'b0;
        rd_val          = 1'b0;
        rd_data         = '0;
        wr_rdy          = 1'b0;
        bp_en           = 1'b0;
        errors          = 0;
        timeouts        = 0;
        received        = 0;
        total_exp       = 0;
        rd_rdy_low_seen = 1'b0;
        aborted         = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            build_layer(r);
            total_exp += ROWS[r].exp_words;
        end

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        #(CLK_PERIOD / 4);
        assert (rd_rdy === 1'b1 && wr_val === 1'b0) else begin
            $display("FAILED at %0t: after reset rd_rdy=%b wr_val=%b, expected 1 and 0",
                     $time, rd_rdy, wr_val);
            errors++;
        end

        fork
            watch_output();
        join_none

        // layers back to back with no idle cycle between them
        @(negedge clk);
        for (int i = 0; i < stim_q.size() && !aborted; i++) begin
            send_word(stim_q[i], stim_bp_q[i]);
        end
        rd_val = 1'b0;
        #(CLK_PERIOD / 4);
        bp_en = 1'b0;

        waited = 0;
        while (received < total_exp && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (received < total_exp) begin
            $display("timeout: only %0d of %0d output words arrived", received, total_exp);
            timeouts++;
        end
        // idle cycles to catch stray words
        repeat (10) @(negedge clk);
        assert (received == total_exp && exp_q.size() == 0) else begin
            $display("FAILED at %0t: %0d output words, table expects %0d, %0d still queued",
                     $time, received, total_exp, exp_q.size());
            errors++;
        end
        assert (rd_rdy_low_seen) else begin
            $display("rd_rdy never dropped during the back-pressure layers");
            errors++;
        end

        $display("words %0d of %0d, errors %0d, timeouts %0d",
                 received, total_exp, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
source/ts3d_pkg.sv
source/ts3d_ifs.sv
source/layer_cfg.sv
source/global_buffer.sv
source/pe_array.sv
source/max_pool.sv
source/pool_out.sv
source/ts3d_top.sv
verification/ts3d_sva.sv
verification/ts3d_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module ts3d_tb -f compile.f -o ts3d_sim

result=$(./obj_dir/ts3d_sim) || true
printf '%s\n' "$result"

echo "$result" | grep -q "^No errors$"
